//--- src/soc_pkg.sv
package soc_pkg;

    // Bus widths
    parameter int ADDR_W = 32;
    parameter int DATA_W = 32;
    parameter int STRB_W = DATA_W / 8;  // One strobe per byte lane

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [1:0]        resp_t;
    typedef logic [63:0]       mtime_t;  // Machine timer and compare

    // AXI response codes
    parameter resp_t RESP_OKAY   = 2'd0;
    parameter resp_t RESP_SLVERR = 2'd2;
    parameter resp_t RESP_DECERR = 2'd3;

    // CLINT window, upper 16 address bits
    parameter addr_t CLINT_BASE = 32'h0200_0000;
    parameter addr_t CLINT_MASK = 32'hFFFF_0000;

    // CLINT register offsets inside the window
    parameter logic [15:0] MSIP_OFS     = 16'h0000;
    parameter logic [15:0] MTIMECMP_OFS = 16'h4000;  // Low word, high at +4
    parameter logic [15:0] MTIME_OFS    = 16'hBFF8;  // Low word, high at +4

endpackage

//--- src/bus_req_if.sv
`timescale 1ns/1ns

interface bus_req_if;
    import soc_pkg::*;

    logic  req_valid;
    logic  req_ready;
    logic  write;      // 1 for store, 0 for load
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
    logic  rsp_valid;
    logic  rsp_ready;
    data_t rdata;      // Zero on writes
    resp_t resp;

    // Requester side
    modport mgr (
        output req_valid, write, addr, wdata, wstrb, rsp_ready,
        input  req_ready, rsp_valid, rdata, resp
    );

    // Responder side
    modport sub (
        input  req_valid, write, addr, wdata, wstrb, rsp_ready,
        output req_ready, rsp_valid, rdata, resp
    );

endinterface

//--- src/xbar_slot.sv
`timescale 1ns/1ns

module xbar_slot (
    input  logic           clock,
    input  logic           arst_n,
    input  logic           arvalid,
    output logic           arready,
    input  soc_pkg::addr_t araddr,
    output logic           rvalid,
    input  logic           rready,
    output soc_pkg::data_t rdata,
    output soc_pkg::resp_t rresp,
    input  logic           awvalid,
    output logic           awready,
    input  soc_pkg::addr_t awaddr,
    input  logic           wvalid,
    output logic           wready,
    input  soc_pkg::data_t wdata,
    input  soc_pkg::strb_t wstrb,
    output logic           bvalid,
    input  logic           bready,
    output soc_pkg::resp_t bresp,
    bus_req_if.mgr         req
);
    import soc_pkg::*;

    typedef enum logic [1:0] {EMPTY, ISSUE, RESPOND} slot_state_e;

    slot_state_e state;
    logic        sent;      // Router has taken the request
    logic        take_rd;
    logic        take_wr;
    logic        wr_q;      // Captured transfer kind
    addr_t       addr_q;
    data_t       wdata_q;
    strb_t       wstrb_q;
    data_t       rdata_q;
    resp_t       resp_q;

    assign arready = (state == EMPTY);
    assign awready = (state == EMPTY) && awvalid && wvalid && !arvalid;  // Read wins a tie
    assign wready  = awready;                                           // AW and W move together
    assign take_rd = arready && arvalid;
    assign take_wr = awready;

    // Request toward the router
    assign req.req_valid = (state == ISSUE) && !sent;
    assign req.write     = wr_q;
    assign req.addr      = addr_q;
    assign req.wdata     = wdata_q;
    assign req.wstrb     = wstrb_q;
    assign req.rsp_ready = (state == ISSUE) && sent;

    // Stored response, steered by kind
    assign rvalid = (state == RESPOND) && !wr_q;
    assign bvalid = (state == RESPOND) && wr_q;
    assign rdata  = rdata_q;
    assign rresp  = resp_q;
    assign bresp  = resp_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= EMPTY;
            sent  <= 1'b0;
        end else begin
            case (state)
                EMPTY: begin
                    if (take_rd || take_wr) begin
                        state <= ISSUE;
                        sent  <= 1'b0;
                    end
                end
                ISSUE: begin
                    if (req.req_valid && req.req_ready)
                        sent <= 1'b1;
                    if (req.rsp_valid && req.rsp_ready)
                        state <= RESPOND;
                end
                RESPOND: begin
                    if ((rvalid && rready) || (bvalid && bready))
                        state <= EMPTY;  // Back-pressure keeps us here
                end
                default: state <= EMPTY;
            endcase
        end
    end

    // Holding registers
    always_ff @(posedge clock) begin
        if (take_rd || take_wr) begin
            wr_q    <= !take_rd;
            addr_q  <= take_rd ? araddr : awaddr;
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
        if (req.rsp_valid && req.rsp_ready) begin
            rdata_q <= req.rdata;
            resp_q  <= req.resp;
        end
    end

endmodule

//--- src/xbar_router.sv
`timescale 1ns/1ns

module xbar_router #(
    parameter int NUM_MGR = 2
) (
    input  logic           clock,
    input  logic           arst_n,
    bus_req_if.sub         slots [NUM_MGR],
    bus_req_if.mgr         clint_bus,
    output logic           mem_arvalid,
    input  logic           mem_arready,
    output soc_pkg::addr_t mem_araddr,
    input  logic           mem_rvalid,
    output logic           mem_rready,
    input  soc_pkg::data_t mem_rdata,
    input  soc_pkg::resp_t mem_rresp,
    output logic           mem_awvalid,
    input  logic           mem_awready,
    output soc_pkg::addr_t mem_awaddr,
    output logic           mem_wvalid,
    input  logic           mem_wready,
    output soc_pkg::data_t mem_wdata,
    output soc_pkg::strb_t mem_wstrb,
    input  logic           mem_bvalid,
    output logic           mem_bready,
    input  soc_pkg::resp_t mem_bresp
);
    import soc_pkg::*;

    localparam int IDX_W = (NUM_MGR > 1) ? $clog2(NUM_MGR) : 1;

    typedef logic [IDX_W-1:0] idx_t;
    typedef enum logic [2:0] {
        IDLE, MEM_ADDR, MEM_RESP, CLINT_REQ, CLINT_RESP, REPLY
    } rtr_state_e;

    rtr_state_e         state;
    idx_t               gnt_q;      // Current grant, also the round-robin pointer
    idx_t               gnt_nxt;
    logic               any_req;
    logic               is_clint;
    logic               aw_done;    // AW handshake seen
    logic               w_done;     // W handshake seen
    logic [NUM_MGR-1:0] req_vld;
    logic [NUM_MGR-1:0] req_wr;
    logic [NUM_MGR-1:0] rsp_rdy;
    addr_t              req_addr  [NUM_MGR];
    data_t              req_wdata [NUM_MGR];
    strb_t              req_wstrb [NUM_MGR];
    logic               wr_q;
    addr_t              addr_q;
    data_t              wdata_q;
    strb_t              wstrb_q;
    data_t              rdata_q;
    resp_t              resp_q;

    // Flatten the slot interfaces so they can be indexed by the grant
    for (genvar g = 0; g < NUM_MGR; g++) begin : g_slot
        assign req_vld[g]   = slots[g].req_valid;
        assign req_wr[g]    = slots[g].write;
        assign req_addr[g]  = slots[g].addr;
        assign req_wdata[g] = slots[g].wdata;
        assign req_wstrb[g] = slots[g].wstrb;
        assign rsp_rdy[g]   = slots[g].rsp_ready;
        assign slots[g].req_ready = (state == IDLE) && any_req && (gnt_nxt == idx_t'(g));
        assign slots[g].rsp_valid = (state == REPLY) && (gnt_q == idx_t'(g));
        assign slots[g].rdata     = rdata_q;
        assign slots[g].resp      = resp_q;
    end

    // Round-robin pick, nearest slot after the last grant wins
    always_comb begin : rr_pick
        int idx;
        gnt_nxt = gnt_q;
        any_req = 1'b0;
        for (int k = NUM_MGR; k >= 1; k--) begin
            idx = (int'(gnt_q) + k) % NUM_MGR;
            if (req_vld[idx]) begin
                gnt_nxt = idx_t'(idx);
                any_req = 1'b1;
            end
        end
    end

    assign is_clint = (req_addr[gnt_nxt] & CLINT_MASK) == CLINT_BASE;  // Only decode point

    // Memory side
    assign mem_arvalid = (state == MEM_ADDR) && !wr_q;
    assign mem_awvalid = (state == MEM_ADDR) && wr_q && !aw_done;
    assign mem_wvalid  = (state == MEM_ADDR) && wr_q && !w_done;
    assign mem_araddr  = addr_q;
    assign mem_awaddr  = addr_q;
    assign mem_wdata   = wdata_q;
    assign mem_wstrb   = wstrb_q;
    assign mem_rready  = (state == MEM_RESP) && !wr_q;
    assign mem_bready  = (state == MEM_RESP) && wr_q;

    // CLINT side
    assign clint_bus.req_valid = (state == CLINT_REQ);
    assign clint_bus.write     = wr_q;
    assign clint_bus.addr      = addr_q;
    assign clint_bus.wdata     = wdata_q;
    assign clint_bus.wstrb     = wstrb_q;
    assign clint_bus.rsp_ready = (state == CLINT_RESP);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            gnt_q   <= idx_t'(NUM_MGR - 1);  // Slot 0 goes first
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (any_req) begin
                        gnt_q <= gnt_nxt;
                        state <= is_clint ? CLINT_REQ : MEM_ADDR;
                    end
                end
                MEM_ADDR: begin
                    if (wr_q) begin
                        if (mem_awvalid && mem_awready)
                            aw_done <= 1'b1;
                        if (mem_wvalid && mem_wready)
                            w_done <= 1'b1;
                        if ((aw_done || mem_awready) && (w_done || mem_wready)) begin
                            state   <= MEM_RESP;
                            aw_done <= 1'b0;
                            w_done  <= 1'b0;
                        end
                    end else if (mem_arready) begin
                        state <= MEM_RESP;
                    end
                end
                MEM_RESP: begin
                    if ((mem_rvalid && mem_rready) || (mem_bvalid && mem_bready))
                        state <= REPLY;
                end
                CLINT_REQ: begin
                    if (clint_bus.req_ready)
                        state <= CLINT_RESP;
                end
                CLINT_RESP: begin
                    if (clint_bus.rsp_valid)
                        state <= REPLY;
                end
                REPLY: begin
                    if (rsp_rdy[gnt_q])
                        state <= IDLE;  // Slot took the response
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Request and response payload
    always_ff @(posedge clock) begin
        if (state == IDLE && any_req) begin
            wr_q    <= req_wr[gnt_nxt];
            addr_q  <= req_addr[gnt_nxt];
            wdata_q <= req_wdata[gnt_nxt];
            wstrb_q <= req_wstrb[gnt_nxt];
        end
        if (mem_rvalid && mem_rready) begin
            rdata_q <= mem_rdata;
            resp_q  <= mem_rresp;
        end
        if (mem_bvalid && mem_bready) begin
            rdata_q <= '0;
            resp_q  <= mem_bresp;
        end
        if (clint_bus.rsp_valid && clint_bus.rsp_ready) begin
            rdata_q <= clint_bus.rdata;
            resp_q  <= clint_bus.resp;
        end
    end

endmodule

//--- src/clint.sv
`timescale 1ns/1ns

module clint #(
    parameter int TICK_DIV = 1
) (
    input  logic   clock,
    input  logic   arst_n,
    bus_req_if.sub bus,
    output logic   timer_irq,
    output logic   soft_irq
);
    import soc_pkg::*;

    localparam int CNT_W = $clog2(TICK_DIV + 1);

    mtime_t         mtime;
    mtime_t         mtimecmp;
    logic           msip;
    logic [CNT_W-1:0] tick_cnt;
    logic           tick;       // mtime advance strobe
    logic           hs;         // Request handshake
    logic           wr_hs;
    logic [15:0]    ofs;        // Offset inside the CLINT window
    data_t          rd_data;
    logic           map_err;    // Offset not in the register map
    logic           rsp_vld_q;
    data_t          rdata_q;
    resp_t          resp_q;

    // Byte-lane merge for strobed writes
    function automatic data_t merge(input data_t old_w, input data_t new_w, input strb_t strb);
        data_t res;
        res = old_w;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b])
                res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    assign bus.req_ready = !rsp_vld_q;  // One outstanding response
    assign hs            = bus.req_valid && bus.req_ready;
    assign wr_hs         = hs && bus.write;
    assign ofs           = bus.addr[15:0];
    assign tick          = (tick_cnt == CNT_W'(TICK_DIV - 1));
    assign soft_irq      = msip;

    assign bus.rsp_valid = rsp_vld_q;
    assign bus.rdata     = rdata_q;
    assign bus.resp      = resp_q;

    // Register map read mux
    always_comb begin
        rd_data = '0;
        map_err = 1'b0;
        case (ofs)
            MSIP_OFS:             rd_data = {{(DATA_W-1){1'b0}}, msip};
            MTIMECMP_OFS:         rd_data = mtimecmp[31:0];
            MTIMECMP_OFS + 16'd4: rd_data = mtimecmp[63:32];
            MTIME_OFS:            rd_data = mtime[31:0];
            MTIME_OFS + 16'd4:    rd_data = mtime[63:32];
            default:              map_err = 1'b1;
        endcase
    end

    // Timer prescaler
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            tick_cnt <= '0;
        else
            tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
    end

    // Registers, writes land on the handshake edge
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mtime     <= '0;
            mtimecmp  <= '1;   // Far future, no timer interrupt
            msip      <= 1'b0;
            timer_irq <= 1'b0;
        end else begin
            if (wr_hs && ofs == MTIME_OFS)
                mtime[31:0] <= merge(mtime[31:0], bus.wdata, bus.wstrb);
            else if (wr_hs && ofs == MTIME_OFS + 16'd4)
                mtime[63:32] <= merge(mtime[63:32], bus.wdata, bus.wstrb);
            else if (tick)
                mtime <= mtime + 64'd1;
            if (wr_hs && ofs == MTIMECMP_OFS)
                mtimecmp[31:0] <= merge(mtimecmp[31:0], bus.wdata, bus.wstrb);
            if (wr_hs && ofs == MTIMECMP_OFS + 16'd4)
                mtimecmp[63:32] <= merge(mtimecmp[63:32], bus.wdata, bus.wstrb);
            if (wr_hs && ofs == MSIP_OFS && bus.wstrb[0])
                msip <= bus.wdata[0];
            timer_irq <= (mtime >= mtimecmp);
        end
    end

    // Response one cycle after the request
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            rsp_vld_q <= 1'b0;
        else if (hs)
            rsp_vld_q <= 1'b1;
        else if (bus.rsp_ready)
            rsp_vld_q <= 1'b0;
    end

    always_ff @(posedge clock) begin
        if (hs) begin
            rdata_q <= (bus.write || map_err) ? '0 : rd_data;
            resp_q  <= map_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

endmodule

//--- src/soc_top.sv
`timescale 1ns/1ns

module soc_top #(
    parameter int NUM_MGR  = 2,  // 0 fetch, 1 load/store
    parameter int TICK_DIV = 1
) (
    input  logic                                clock,
    input  logic                                arst_n,
    input  logic           [NUM_MGR-1:0]        mgr_arvalid,
    output logic           [NUM_MGR-1:0]        mgr_arready,
    input  soc_pkg::addr_t [NUM_MGR-1:0]        mgr_araddr,
    output logic           [NUM_MGR-1:0]        mgr_rvalid,
    input  logic           [NUM_MGR-1:0]        mgr_rready,
    output soc_pkg::data_t [NUM_MGR-1:0]        mgr_rdata,
    output soc_pkg::resp_t [NUM_MGR-1:0]        mgr_rresp,
    input  logic           [NUM_MGR-1:0]        mgr_awvalid,
    output logic           [NUM_MGR-1:0]        mgr_awready,
    input  soc_pkg::addr_t [NUM_MGR-1:0]        mgr_awaddr,
    input  logic           [NUM_MGR-1:0]        mgr_wvalid,
    output logic           [NUM_MGR-1:0]        mgr_wready,
    input  soc_pkg::data_t [NUM_MGR-1:0]        mgr_wdata,
    input  soc_pkg::strb_t [NUM_MGR-1:0]        mgr_wstrb,
    output logic           [NUM_MGR-1:0]        mgr_bvalid,
    input  logic           [NUM_MGR-1:0]        mgr_bready,
    output soc_pkg::resp_t [NUM_MGR-1:0]        mgr_bresp,
    output logic                                mem_arvalid,
    input  logic                                mem_arready,
    output soc_pkg::addr_t                      mem_araddr,
    input  logic                                mem_rvalid,
    output logic                                mem_rready,
    input  soc_pkg::data_t                      mem_rdata,
    input  soc_pkg::resp_t                      mem_rresp,
    output logic                                mem_awvalid,
    input  logic                                mem_awready,
    output soc_pkg::addr_t                      mem_awaddr,
    output logic                                mem_wvalid,
    input  logic                                mem_wready,
    output soc_pkg::data_t                      mem_wdata,
    output soc_pkg::strb_t                      mem_wstrb,
    input  logic                                mem_bvalid,
    output logic                                mem_bready,
    input  soc_pkg::resp_t                      mem_bresp,
    output logic                                timer_irq,
    output logic                                soft_irq
);

    bus_req_if slot_bus [NUM_MGR] ();  // Slot to router
    bus_req_if clint_bus ();           // Router to CLINT

    // One request slot per manager port
    for (genvar g = 0; g < NUM_MGR; g++) begin : g_mgr
        xbar_slot slot_u (
            .clock   (clock),
            .arst_n  (arst_n),
            .arvalid (mgr_arvalid[g]),
            .arready (mgr_arready[g]),
            .araddr  (mgr_araddr[g]),
            .rvalid  (mgr_rvalid[g]),
            .rready  (mgr_rready[g]),
            .rdata   (mgr_rdata[g]),
            .rresp   (mgr_rresp[g]),
            .awvalid (mgr_awvalid[g]),
            .awready (mgr_awready[g]),
            .awaddr  (mgr_awaddr[g]),
            .wvalid  (mgr_wvalid[g]),
            .wready  (mgr_wready[g]),
            .wdata   (mgr_wdata[g]),
            .wstrb   (mgr_wstrb[g]),
            .bvalid  (mgr_bvalid[g]),
            .bready  (mgr_bready[g]),
            .bresp   (mgr_bresp[g]),
            .req     (slot_bus[g])
        );
    end

    xbar_router #(
        .NUM_MGR (NUM_MGR)
    ) router_u0 (
        .clock       (clock),
        .arst_n      (arst_n),
        .slots       (slot_bus),
        .clint_bus   (clint_bus),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_araddr  (mem_araddr),
        .mem_rvalid  (mem_rvalid),
        .mem_rready  (mem_rready),
        .mem_rdata   (mem_rdata),
        .mem_rresp   (mem_rresp),
        .mem_awvalid (mem_awvalid),
        .mem_awready (mem_awready),
        .mem_awaddr  (mem_awaddr),
        .mem_wvalid  (mem_wvalid),
        .mem_wready  (mem_wready),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_bvalid  (mem_bvalid),
        .mem_bready  (mem_bready),
        .mem_bresp   (mem_bresp)
    );

    clint #(
        .TICK_DIV (TICK_DIV)
    ) clint_u0 (
        .clock     (clock),
        .arst_n    (arst_n),
        .bus       (clint_bus),
        .timer_irq (timer_irq),
        .soft_irq  (soft_irq)
    );

endmodule

//--- tb/soc_tb_tasks.svh
localparam addr_t MSIP_A     = 32'h0200_0000;
localparam addr_t MTCMP_LO_A = 32'h0200_4000;
localparam addr_t MTCMP_HI_A = 32'h0200_4004;
localparam addr_t MTIME_LO_A = 32'h0200_BFF8;
localparam addr_t UNMAP_A    = 32'h0200_1000;  // Inside CLINT window, no register
localparam resp_t EXP_OKAY   = 2'd0;
localparam resp_t EXP_SLVERR = 2'd2;

task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
        $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
        errs++;
    end
endtask

task automatic bus_read(input int idx, input addr_t addr, output data_t data, output resp_t resp);
    after_edge();
    mgr_arvalid[idx] = 1'b1;
    mgr_araddr[idx]  = addr;
    do @(negedge clock); while (!mgr_arready[idx]);
    after_edge();
    mgr_arvalid[idx] = 1'b0;
    while (!mgr_rvalid[idx])
        @(negedge clock);
    data = mgr_rdata[idx];
    resp = mgr_rresp[idx];
    after_edge();  // rready high, R taken on that edge
endtask

task automatic mgr_read(input int idx, input addr_t addr, input data_t exp_data,
                        input resp_t exp_resp);
    data_t d;
    resp_t r;
    bus_read(idx, addr, d, r);
    check_val($sformatf("mgr_rdata[%0d]", idx), d, exp_data);
    check_val($sformatf("mgr_rresp[%0d]", idx), r, exp_resp);
endtask

task automatic mgr_write(input int idx, input addr_t addr, input data_t data,
                         input strb_t strb, input resp_t exp_resp);
    logic aw_hs;
    logic w_hs;
    after_edge();
    mgr_awvalid[idx] = 1'b1;
    mgr_awaddr[idx]  = addr;
    mgr_wvalid[idx]  = 1'b1;
    mgr_wdata[idx]   = data;
    mgr_wstrb[idx]   = strb;
    do begin
        @(negedge clock);
        aw_hs = mgr_awvalid[idx] && mgr_awready[idx];
        w_hs  = mgr_wvalid[idx] && mgr_wready[idx];
        after_edge();
        if (aw_hs)
            mgr_awvalid[idx] = 1'b0;  // AW taken on that edge
        if (w_hs)
            mgr_wvalid[idx] = 1'b0;   // W taken on that edge
    end while (mgr_awvalid[idx] || mgr_wvalid[idx]);
    while (!mgr_bvalid[idx])
        @(negedge clock);
    check_val($sformatf("mgr_bresp[%0d]", idx), mgr_bresp[idx], exp_resp);
    after_edge();
endtask

task automatic test_reset();
    cur_test = "reset state";
    @(negedge clock);
    check_val("mgr_rvalid", mgr_rvalid, 0);
    check_val("mgr_bvalid", mgr_bvalid, 0);
    check_val("mem_arvalid", mem_arvalid, 0);
    check_val("mem_awvalid", mem_awvalid, 0);
    check_val("mem_wvalid", mem_wvalid, 0);
    check_val("mem_rready", mem_rready, 0);
    check_val("mem_bready", mem_bready, 0);
    check_val("timer_irq", timer_irq, 0);
    check_val("soft_irq", soft_irq, 0);
    mgr_read(0, MTCMP_LO_A, 32'hFFFF_FFFF, EXP_OKAY);
    mgr_read(1, MTCMP_HI_A, 32'hFFFF_FFFF, EXP_OKAY);
endtask

task automatic test_mem_routing();
    addr_t a;
    data_t d;
    data_t d2;
    cur_test = "memory routing";
    for (int m = 0; m < 2; m++) begin
        for (int k = 0; k < 4; k++) begin
            a = 32'h8000_0000 + addr_t'(m * 64 + k * 12);  // Distinct model words
            d = rand_word();
            mgr_write(m, a, d, 4'hF, EXP_OKAY);
            check_val("mem_awaddr", last_awaddr, a);
            check_val("mem_wstrb", last_wstrb, 4'hF);
            mgr_read(m, a, d, EXP_OKAY);
            check_val("mem_araddr", last_araddr, a);
        end
    end
    a  = 32'h1000_0080;
    d  = rand_word();
    d2 = rand_word();
    mgr_write(1, a, d, 4'hF, EXP_OKAY);
    mgr_write(1, a, d2, 4'b0101, EXP_OKAY);  // Bytes 0 and 2 only
    check_val("mem_wstrb", last_wstrb, 4'b0101);
    mgr_read(0, a, {d[31:24], d2[23:16], d[15:8], d2[7:0]}, EXP_OKAY);
endtask

task automatic test_concurrent();
    data_t d0;
    data_t d1;
    cur_test = "concurrent managers";
    d0 = rand_word();
    d1 = rand_word();
    fork
        mgr_write(0, 32'h0000_01F0, d0, 4'hF, EXP_OKAY);
        mgr_write(1, 32'h4000_00F4, d1, 4'hF, EXP_OKAY);
    join
    fork
        mgr_read(0, 32'h4000_00F4, d1, EXP_OKAY);  // Cross-read the other's word
        mgr_read(1, 32'h0000_01F0, d0, EXP_OKAY);
    join
endtask

task automatic test_soft_irq();
    cur_test = "software interrupt";
    mgr_write(1, MSIP_A, 32'h1, 4'hF, EXP_OKAY);
    check_val("soft_irq", soft_irq, 1);
    mgr_read(0, MSIP_A, 32'h1, EXP_OKAY);
    mgr_write(0, MSIP_A, 32'h0, 4'hF, EXP_OKAY);
    check_val("soft_irq", soft_irq, 0);
    mgr_read(1, MSIP_A, 32'h0, EXP_OKAY);
endtask

task automatic test_timer();
    data_t t0;
    data_t t1;
    resp_t r;
    cur_test = "timer";
    bus_read(0, MTIME_LO_A, t0, r);
    bus_read(0, MTIME_LO_A, t1, r);
    check_val("mgr_rresp[0]", r, EXP_OKAY);
    checks++;
    assert (t1 >= t0) else begin
        $display("ERR mgr_rdata[0] mtime went from 0x%0h back to 0x%0h", t0, t1);
        errs++;
    end
    mgr_write(1, MTCMP_LO_A, 32'h200, 4'hF, EXP_OKAY);
    mgr_write(1, MTCMP_HI_A, 32'h0, 4'hF, EXP_OKAY);
    while (!timer_irq)
        @(negedge clock);
    bus_read(1, MTIME_LO_A, t1, r);
    checks++;
    assert (t1 >= 32'h200) else begin
        $display("ERR mgr_rdata[1] got 0x%0h expected at least 0x200", t1);
        errs++;
    end
    mgr_write(1, MTCMP_HI_A, 32'hFFFF_FFFF, 4'hF, EXP_OKAY);
    check_val("timer_irq", timer_irq, 0);
endtask

task automatic test_decode_err();
    cur_test = "decode errors";
    mgr_read(0, UNMAP_A, 32'h0, EXP_SLVERR);
    mgr_read(1, UNMAP_A, 32'h0, EXP_SLVERR);
endtask

//--- tb/soc_tb.sv
`timescale 1ns/1ns

module soc_tb;
    import soc_pkg::*;

    localparam int CYCLE_LIMIT = 20000;  // ~40 transfers under 30 cycles each, plus timer wait

    logic           clock;
    logic           arst_n;
    logic  [1:0]    mgr_arvalid, mgr_arready, mgr_rvalid, mgr_rready;
    logic  [1:0]    mgr_awvalid, mgr_awready, mgr_wvalid, mgr_wready;
    logic  [1:0]    mgr_bvalid, mgr_bready;
    addr_t [1:0]    mgr_araddr, mgr_awaddr;
    data_t [1:0]    mgr_rdata, mgr_wdata;
    strb_t [1:0]    mgr_wstrb;
    resp_t [1:0]    mgr_rresp, mgr_bresp;
    logic           mem_arvalid, mem_arready, mem_rvalid, mem_rready;
    logic           mem_awvalid, mem_awready, mem_wvalid, mem_wready;
    logic           mem_bvalid, mem_bready;
    addr_t          mem_araddr, mem_awaddr;
    data_t          mem_rdata, mem_wdata;
    strb_t          mem_wstrb;
    resp_t          mem_rresp, mem_bresp;
    logic           timer_irq, soft_irq;

    logic  [15:0]   lfsr = 16'd46;     // Seed
    data_t          mem_words [64];    // Memory model storage
    addr_t          last_araddr;       // What the model last saw
    addr_t          last_awaddr;
    strb_t          last_wstrb;
    int             checks = 0;
    int             errs = 0;
    int             cycles = 0;
    string          cur_test = "startup";

    soc_top #(
        .NUM_MGR  (2),
        .TICK_DIV (1)
    ) dut0 (.*);

    always #5 clock = ~clock;

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic int rand_delay();
        logic [1:0] d;
        d[1] = lfsr_step();
        d[0] = lfsr_step();
        return int'(d);  // 0 to 3 cycles
    endfunction

    function automatic data_t rand_word();
        data_t w;
        for (int b = 0; b < 32; b++)
            w[b] = lfsr_step();
        return w;
    endfunction

    task automatic after_edge();
        @(posedge clock);
        #1;  // Inputs change just after the edge
    endtask

    `include "soc_tb_tasks.svh"

    // Memory responder, one transfer at a time
    task automatic serve_read();
        int dly;
        dly = rand_delay();
        after_edge();
        repeat (dly) after_edge();
        mem_arready = 1'b1;
        @(negedge clock);                 // arvalid holds until taken
        last_araddr = mem_araddr;
        after_edge();
        mem_arready = 1'b0;
        dly = rand_delay();
        repeat (dly) after_edge();
        mem_rvalid = 1'b1;
        mem_rdata  = mem_words[last_araddr[7:2]];
        mem_rresp  = 2'd0;
        do @(negedge clock); while (!mem_rready);
        after_edge();
        mem_rvalid = 1'b0;
    endtask

    task automatic serve_write();
        int   d_aw;
        int   d_w;
        int   n;
        logic got_aw;
        logic got_w;
        data_t wd;
        d_aw   = rand_delay();
        d_w    = rand_delay();
        got_aw = 1'b0;
        got_w  = 1'b0;
        n      = 0;
        after_edge();
        while (!(got_aw && got_w)) begin  // AW and W may finish in either order
            mem_awready = !got_aw && (n >= d_aw);
            mem_wready  = !got_w && (n >= d_w);
            @(negedge clock);
            if (mem_awvalid && mem_awready) begin
                got_aw      = 1'b1;
                last_awaddr = mem_awaddr;
            end
            if (mem_wvalid && mem_wready) begin
                got_w      = 1'b1;
                wd         = mem_wdata;
                last_wstrb = mem_wstrb;
            end
            after_edge();
            n++;
        end
        mem_awready = 1'b0;
        mem_wready  = 1'b0;
        for (int b = 0; b < 4; b++) begin
            if (last_wstrb[b])
                mem_words[last_awaddr[7:2]][8*b +: 8] = wd[8*b +: 8];
        end
        repeat (rand_delay()) after_edge();
        mem_bvalid = 1'b1;
        mem_bresp  = 2'd0;
        do @(negedge clock); while (!mem_bready);
        after_edge();
        mem_bvalid = 1'b0;
    endtask

    initial begin : mem_model
        for (int i = 0; i < 64; i++)
            mem_words[i] = 32'h6C00_0000 ^ (32'(i) << 2) ^ (32'(i) << 20);  // Whole-address fill
        forever begin
            @(negedge clock);
            if (mem_arvalid)
                serve_read();
            else if (mem_awvalid || mem_wvalid)
                serve_write();
        end
    end

    // Watchdog
    always @(posedge clock) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, test '%s' hung", cycles, cur_test);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin : main
        clock       = 1'b0;
        arst_n      = 1'b0;
        mgr_arvalid = '0;
        mgr_araddr  = '0;
        mgr_rready  = '1;  // Managers always accept responses
        mgr_awvalid = '0;
        mgr_awaddr  = '0;
        mgr_wvalid  = '0;
        mgr_wdata   = '0;
        mgr_wstrb   = '0;
        mgr_bready  = '1;
        mem_arready = 1'b0;
        mem_rvalid  = 1'b0;
        mem_rdata   = '0;
        mem_rresp   = '0;
        mem_awready = 1'b0;
        mem_wready  = 1'b0;
        mem_bvalid  = 1'b0;
        mem_bresp   = '0;
        repeat (5) @(posedge clock);
        #1;
        arst_n = 1'b1;
        test_reset();
        test_mem_routing();
        test_concurrent();
        test_soft_irq();
        test_timer();
        test_decode_err();
        after_edge();
        $display("Checks run %0d, errors %0d", checks, errs);
        if (errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+tb
src/soc_pkg.sv
src/bus_req_if.sv
src/xbar_slot.sv
src/xbar_router.sv
src/clint.sv
src/soc_top.sv
tb/soc_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the soc_tb testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module soc_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vsoc_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
    exit 0
fi
exit 1
